/* build.f */
design/isp_pkg.sv
design/isp_request_regs.sv
design/isp_axi_read.sv
design/isp_pixel_gain.sv
design/isp_axi_write.sv
design/isp_luma_accum.sv
design/isp_top.sv
verification/isp_clk_gen.sv
verification/isp_dram_model.sv
verification/isp_chk.sv
verification/isp_tb.sv

/* design/isp_axi_read.sv */
`timescale 1ns/1ps

module isp_axi_read (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          base_addr,
    input  logic                 arready,
    input  logic                 rvalid,
    input  logic [127:0]         rdata,
    input  logic                 rlast,
    input  logic                 slot_free,
    output logic                 arvalid,
    output logic [31:0]          araddr,
    output logic [7:0]           arlen,
    output logic                 rready,
    output logic                 beat_valid,
    output isp_pkg::pixel_beat_t beat_data
);

    logic r_active;
    logic r_take;

    // ==================================================================
    // read address
    // ==================================================================
    assign arlen = isp_pkg::BURST_LEN;

    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= base_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (start) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    // ==================================================================
    // read data
    // ==================================================================
    // burst window, open from the address handshake to rlast
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_active <= 1'b0;
        end else if (arvalid && arready) begin
            r_active <= 1'b1;
        end else if (r_take && rlast) begin
            r_active <= 1'b0;
        end
    end

    // stall while the write side still holds a beat
    assign rready = r_active & slot_free;
    assign r_take = rvalid & rready;

    assign beat_valid     = r_take;
    assign beat_data.word = rdata;

endmodule

/* design/isp_axi_write.sv */
`timescale 1ns/1ps

module isp_axi_write (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          base_addr,
    input  logic                 beat_valid,
    input  isp_pkg::pixel_beat_t beat_in,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 awvalid,
    output logic [31:0]          awaddr,
    output logic [7:0]           awlen,
    output logic                 wvalid,
    output logic [127:0]         wdata,
    output logic                 wlast,
    output logic                 bready,
    output logic                 slot_free,
    output logic                 write_done
);

    logic [7:0] beat_cnt;
    logic       last_beat;

    // ==================================================================
    // write address
    // ==================================================================
    assign awlen = isp_pkg::BURST_LEN;

    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= base_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvalid <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
        end else if (awready) begin
            awvalid <= 1'b0;
        end
    end

    // ==================================================================
    // one-beat slot
    // ==================================================================
    assign slot_free = ~wvalid | wready;
    assign last_beat = beat_cnt == 8'(isp_pkg::BURST_BEATS - 1);

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            wdata <= beat_in.word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end else if (beat_valid) begin
            wvalid <= 1'b1;
            wlast  <= last_beat;
        end else if (wready) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end
    end

    // counts loaded beats, wraps after the last one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            beat_cnt <= last_beat ? 8'd0 : beat_cnt + 8'd1;
        end
    end

    // ==================================================================
    // write response
    // ==================================================================
    assign bready = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_done <= 1'b0;
        end else begin
            write_done <= bvalid & bready;
        end
    end

endmodule

/* design/isp_luma_accum.sv */
`timescale 1ns/1ps

module isp_luma_accum (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 beat_valid,
    input  isp_pkg::pixel_beat_t beat_in,
    input  logic                 write_done,
    output logic                 out_valid,
    output logic [7:0]           out_data
);

    logic [5:0]  ch_beat;
    logic [1:0]  channel;
    logic        ch_last;
    logic [6:0]  gray [isp_pkg::PIXELS_PER_BEAT];
    logic [7:0]  sum1 [8];
    logic [8:0]  sum2 [4];
    logic [9:0]  sum3 [2];
    logic [10:0] sum4;
    logic [4:0]  stage_vld;
    logic [17:0] acc;
    logic [7:0]  acc_cnt;
    logic        acc_last;
    logic        burst_done;
    logic        wr_done;
    logic        fire;

    // ==================================================================
    // channel tracking
    // ==================================================================
    assign ch_last = ch_beat == 6'(isp_pkg::BEATS_PER_CHANNEL - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_beat <= '0;
            channel <= '0;
        end else if (beat_valid) begin
            ch_beat <= ch_beat + 6'd1;
            if (ch_last) begin
                channel <= (channel == 2'(isp_pkg::CHANNELS - 1)) ? 2'd0 : channel + 2'd1;
            end
        end
    end

    // ==================================================================
    // grey weights and adder tree
    // ==================================================================
    // green lanes count half, red and blue a quarter
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int i = 0; i < isp_pkg::PIXELS_PER_BEAT; i++) begin
                gray[i] <= (channel == 2'd1) ? 7'(beat_in.pix[i] >> 1) : 7'(beat_in.pix[i] >> 2);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            sum1[i] <= gray[2*i] + gray[2*i+1];
        end
        for (int i = 0; i < 4; i++) begin
            sum2[i] <= sum1[2*i] + sum1[2*i+1];
        end
        for (int i = 0; i < 2; i++) begin
            sum3[i] <= sum2[2*i] + sum2[2*i+1];
        end
        sum4 <= sum3[0] + sum3[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld <= '0;
        end else begin
            stage_vld <= {stage_vld[3:0], beat_valid};
        end
    end

    // ==================================================================
    // accumulate and report
    // ==================================================================
    assign acc_last = acc_cnt == 8'(isp_pkg::BURST_BEATS - 1);
    assign fire     = burst_done & wr_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc        <= '0;
            acc_cnt    <= '0;
            burst_done <= 1'b0;
            wr_done    <= 1'b0;
        end else if (fire) begin
            acc        <= '0;
            acc_cnt    <= '0;
            burst_done <= 1'b0;
            wr_done    <= 1'b0;
        end else begin
            if (stage_vld[4]) begin
                acc     <= acc + 18'(sum4);
                acc_cnt <= acc_last ? 8'd0 : acc_cnt + 8'd1;
                if (acc_last) begin
                    burst_done <= 1'b1;
                end
            end
            if (write_done) begin
                wr_done <= 1'b1;
            end
        end
    end

    // out_data stays zero outside the result cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= fire;
            out_data  <= fire ? 8'(acc >> isp_pkg::LUMA_SHIFT) : 8'd0;
        end
    end

endmodule

/* design/isp_pixel_gain.sv */
`timescale 1ns/1ps

module isp_pixel_gain (
    input  isp_pkg::pixel_beat_t beat_in,
    input  logic [1:0]           ratio,
    output isp_pkg::pixel_beat_t beat_out
);

    always_comb begin
        for (int i = 0; i < isp_pkg::PIXELS_PER_BEAT; i++) begin
            case (ratio)
                2'd0: begin
                    beat_out.pix[i] = beat_in.pix[i] >> 2;
                end
                2'd1: begin
                    beat_out.pix[i] = beat_in.pix[i] >> 1;
                end
                isp_pkg::RATIO_SAT: begin
                    // doubling overflows once the top bit is set
                    if (beat_in.pix[i][7]) begin
                        beat_out.pix[i] = 8'hff;
                    end else begin
                        beat_out.pix[i] = {beat_in.pix[i][6:0], 1'b0};
                    end
                end
                default: begin
                    beat_out.pix[i] = beat_in.pix[i];
                end
            endcase
        end
    end

endmodule

/* design/isp_pkg.sv */
package isp_pkg;

    // ==================================================================
    // bus and picture geometry
    // ==================================================================
    localparam int BEAT_BITS         = 128;
    localparam int PIXELS_PER_BEAT   = 16;
    localparam int BEATS_PER_CHANNEL = 64;
    localparam int CHANNELS          = 3;
    localparam int BURST_BEATS       = BEATS_PER_CHANNEL * CHANNELS;

    localparam logic [7:0]  BURST_LEN     = 8'd191;
    localparam logic [31:0] PIC_BASE_ADDR = 32'h0001_0000;
    localparam logic [31:0] PIC_BYTES     = 32'd3072;

    // ==================================================================
    // fixed AXI attributes
    // ==================================================================
    localparam logic [2:0] AXI_SIZE_16B   = 3'b100;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_ID         = 4'd0;

    // ==================================================================
    // exposure and luma
    // ==================================================================
    localparam int         LUMA_SHIFT = 10;
    localparam logic [1:0] RATIO_SAT  = 2'd3;

    // one bus beat, seen as a raw word or as pixel bytes
    // pixel 0 sits in the low byte
    typedef union packed {
        logic [BEAT_BITS-1:0]             word;
        logic [PIXELS_PER_BEAT-1:0][7:0] pix;
    } pixel_beat_t;

endpackage

/* design/isp_request_regs.sv */
`timescale 1ns/1ps

module isp_request_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [3:0]  in_pic_no,
    input  logic [1:0]  in_ratio_mode,
    input  logic        done,
    output logic        start,
    output logic        busy,
    output logic [31:0] base_addr,
    output logic [1:0]  ratio
);

    logic take;

    // a request is ignored while one is already running
    assign take = in_valid & ~busy;

    always_ff @(posedge clk) begin
        if (take) begin
            base_addr <= isp_pkg::PIC_BASE_ADDR + 32'(in_pic_no) * isp_pkg::PIC_BYTES;
            ratio     <= in_ratio_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= take;
        end
    end

    // busy rises together with start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

endmodule

/* design/isp_top.sv */
`timescale 1ns/1ps

module isp_top (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  logic [3:0]   in_pic_no,
    input  logic [1:0]   in_ratio_mode,
    output logic         out_valid,
    output logic [7:0]   out_data,

    // write address channel
    output logic [3:0]   awid_s_inf,
    output logic [31:0]  awaddr_s_inf,
    output logic [2:0]   awsize_s_inf,
    output logic [1:0]   awburst_s_inf,
    output logic [7:0]   awlen_s_inf,
    output logic         awvalid_s_inf,
    input  logic         awready_s_inf,

    // write data channel
    output logic [127:0] wdata_s_inf,
    output logic         wlast_s_inf,
    output logic         wvalid_s_inf,
    input  logic         wready_s_inf,

    // write response channel
    input  logic         bvalid_s_inf,
    output logic         bready_s_inf,

    // read address channel
    output logic [3:0]   arid_s_inf,
    output logic [31:0]  araddr_s_inf,
    output logic [7:0]   arlen_s_inf,
    output logic [2:0]   arsize_s_inf,
    output logic [1:0]   arburst_s_inf,
    output logic         arvalid_s_inf,
    input  logic         arready_s_inf,

    // read data channel
    input  logic [127:0] rdata_s_inf,
    input  logic         rlast_s_inf,
    input  logic         rvalid_s_inf,
    output logic         rready_s_inf
);

    logic                 start;
    logic [31:0]          base_addr;
    logic [1:0]           ratio;
    logic                 slot_free;
    logic                 beat_valid;
    logic                 write_done;
    isp_pkg::pixel_beat_t beat_raw;
    isp_pkg::pixel_beat_t beat_scaled;

    assign awid_s_inf    = isp_pkg::AXI_ID;
    assign awsize_s_inf  = isp_pkg::AXI_SIZE_16B;
    assign awburst_s_inf = isp_pkg::AXI_BURST_INCR;
    assign arid_s_inf    = isp_pkg::AXI_ID;
    assign arsize_s_inf  = isp_pkg::AXI_SIZE_16B;
    assign arburst_s_inf = isp_pkg::AXI_BURST_INCR;

    isp_request_regs u_req (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .done          (out_valid),
        .start         (start),
        .busy          (),
        .base_addr     (base_addr),
        .ratio         (ratio)
    );

    isp_axi_read u_rd (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .base_addr  (base_addr),
        .arready    (arready_s_inf),
        .rvalid     (rvalid_s_inf),
        .rdata      (rdata_s_inf),
        .rlast      (rlast_s_inf),
        .slot_free  (slot_free),
        .arvalid    (arvalid_s_inf),
        .araddr     (araddr_s_inf),
        .arlen      (arlen_s_inf),
        .rready     (rready_s_inf),
        .beat_valid (beat_valid),
        .beat_data  (beat_raw)
    );

    isp_pixel_gain u_gain (
        .beat_in  (beat_raw),
        .ratio    (ratio),
        .beat_out (beat_scaled)
    );

    isp_axi_write u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .base_addr  (base_addr),
        .beat_valid (beat_valid),
        .beat_in    (beat_scaled),
        .awready    (awready_s_inf),
        .wready     (wready_s_inf),
        .bvalid     (bvalid_s_inf),
        .awvalid    (awvalid_s_inf),
        .awaddr     (awaddr_s_inf),
        .awlen      (awlen_s_inf),
        .wvalid     (wvalid_s_inf),
        .wdata      (wdata_s_inf),
        .wlast      (wlast_s_inf),
        .bready     (bready_s_inf),
        .slot_free  (slot_free),
        .write_done (write_done)
    );

    isp_luma_accum u_luma (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat_in    (beat_scaled),
        .write_done (write_done),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module isp_tb -f build.f -o isp_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/isp_sim); then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1

/* verification/isp_chk.sv */
`timescale 1ns/1ps

module isp_chk (
    input logic         clk,
    input logic         rst_n,
    input logic         in_valid,
    input logic [3:0]   in_pic_no,
    input logic         out_valid,
    input logic [7:0]   out_data,
    input logic [3:0]   awid_s_inf,
    input logic [2:0]   awsize_s_inf,
    input logic [1:0]   awburst_s_inf,
    input logic [31:0]  awaddr_s_inf,
    input logic [7:0]   awlen_s_inf,
    input logic         awvalid_s_inf,
    input logic [127:0] wdata_s_inf,
    input logic         wlast_s_inf,
    input logic         wvalid_s_inf,
    input logic         wready_s_inf,
    input logic [3:0]   arid_s_inf,
    input logic [2:0]   arsize_s_inf,
    input logic [1:0]   arburst_s_inf,
    input logic [31:0]  araddr_s_inf,
    input logic [7:0]   arlen_s_inf,
    input logic         arvalid_s_inf
);

    logic [3:0]  pic;
    logic [7:0]  w_cnt;
    logic [31:0] exp_addr;

    assign exp_addr = isp_pkg::PIC_BASE_ADDR + 32'(pic) * isp_pkg::PIC_BYTES;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pic <= '0;
        end else if (in_valid) begin
            pic <= in_pic_no;
        end
    end

    // write beats accepted so far in the burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_cnt <= '0;
        end else if (wvalid_s_inf && wready_s_inf) begin
            w_cnt <= wlast_s_inf ? 8'd0 : w_cnt + 8'd1;
        end
    end

    ar_addr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_s_inf |-> araddr_s_inf == exp_addr
            && arlen_s_inf == 8'(isp_pkg::BURST_BEATS - 1))
        else $error("read address or burst length wrong");

    aw_addr: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_s_inf |-> awaddr_s_inf == exp_addr
            && awlen_s_inf == 8'(isp_pkg::BURST_BEATS - 1))
        else $error("write address or burst length wrong");

    // 16-byte beats, incrementing bursts, ID zero
    ar_attr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_s_inf |-> arid_s_inf == 4'd0 && arburst_s_inf == 2'b01
            && arsize_s_inf == 3'($clog2(isp_pkg::BEAT_BITS / 8)))
        else $error("read burst attributes wrong");

    aw_attr: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_s_inf |-> awid_s_inf == 4'd0 && awburst_s_inf == 2'b01
            && awsize_s_inf == 3'($clog2(isp_pkg::BEAT_BITS / 8)))
        else $error("write burst attributes wrong");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_s_inf && !wready_s_inf |=> wvalid_s_inf && $stable(wdata_s_inf))
        else $error("write data changed before wready");

    w_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_s_inf |-> wlast_s_inf == (w_cnt == 8'(isp_pkg::BURST_BEATS - 1)))
        else $error("wlast not on the last beat of the burst");

    out_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == 8'd0)
        else $error("out_data nonzero without out_valid");

endmodule

/* verification/isp_clk_gen.sv */
`timescale 1ns/1ps

module isp_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for ten cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verification/isp_dram_model.sv */
`timescale 1ns/1ps

module isp_dram_model (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  awaddr_s_inf,
    input  logic         awvalid_s_inf,
    output logic         awready_s_inf,
    input  logic [127:0] wdata_s_inf,
    input  logic         wlast_s_inf,
    input  logic         wvalid_s_inf,
    output logic         wready_s_inf,
    output logic         bvalid_s_inf,
    input  logic         bready_s_inf,
    input  logic [31:0]  araddr_s_inf,
    input  logic         arvalid_s_inf,
    output logic         arready_s_inf,
    output logic [127:0] rdata_s_inf,
    output logic         rlast_s_inf,
    output logic         rvalid_s_inf,
    input  logic         rready_s_inf
);

    // sixteen pictures, one 128-bit beat per entry
    logic [127:0] mem [16 * isp_pkg::BURST_BEATS];
    int           seed = 33286;
    int           r_base;
    int           r_idx;
    int           w_base;
    int           w_idx;
    logic         r_busy;
    logic         w_open;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready_s_inf <= 1'b0;
            awready_s_inf <= 1'b0;
            wready_s_inf  <= 1'b0;
            bvalid_s_inf  <= 1'b0;
            rvalid_s_inf  <= 1'b0;
            rlast_s_inf   <= 1'b0;
            rdata_s_inf   <= '0;
            r_busy        <= 1'b0;
            w_open        <= 1'b0;
            r_base        <= 0;
            r_idx         <= 0;
            w_base        <= 0;
            w_idx         <= 0;
            for (int i = 0; i < 16 * isp_pkg::BURST_BEATS; i++) begin
                mem[i] <= {$random(seed), $random(seed), $random(seed), $random(seed)};
            end
        end else begin
            // ready lines high about three cycles in four
            arready_s_inf <= ($random(seed) & 3) != 0;
            awready_s_inf <= ($random(seed) & 3) != 0;
            wready_s_inf  <= w_open && (($random(seed) & 3) != 0);

            // ==========================================================
            // read side
            // ==========================================================
            if (arvalid_s_inf && arready_s_inf && !r_busy) begin
                r_busy <= 1'b1;
                r_base <= int'((araddr_s_inf - isp_pkg::PIC_BASE_ADDR) >> 4);
                r_idx  <= 0;
            end
            // r_idx counts accepted beats
            if (r_busy && (!rvalid_s_inf || rready_s_inf)) begin
                if (rvalid_s_inf && rlast_s_inf) begin
                    rvalid_s_inf <= 1'b0;
                    rlast_s_inf  <= 1'b0;
                    r_busy       <= 1'b0;
                end else begin
                    r_idx <= r_idx + int'(rvalid_s_inf);
                    if (($random(seed) & 3) != 0) begin
                        rvalid_s_inf <= 1'b1;
                        rdata_s_inf  <= mem[r_base + r_idx + int'(rvalid_s_inf)];
                        rlast_s_inf  <= r_idx + int'(rvalid_s_inf) == isp_pkg::BURST_BEATS - 1;
                    end else begin
                        rvalid_s_inf <= 1'b0;
                        rlast_s_inf  <= 1'b0;
                    end
                end
            end

            // ==========================================================
            // write side
            // ==========================================================
            if (awvalid_s_inf && awready_s_inf && !w_open) begin
                w_open <= 1'b1;
                w_base <= int'((awaddr_s_inf - isp_pkg::PIC_BASE_ADDR) >> 4);
                w_idx  <= 0;
            end
            if (wvalid_s_inf && wready_s_inf) begin
                mem[w_base + w_idx] <= wdata_s_inf;
                w_idx <= w_idx + 1;
                if (wlast_s_inf) begin
                    w_open       <= 1'b0;
                    bvalid_s_inf <= 1'b1;
                end
            end else if (bvalid_s_inf && bready_s_inf) begin
                bvalid_s_inf <= 1'b0;
            end
        end
    end

endmodule

/* verification/isp_tb.sv */
`timescale 1ns/1ps

module isp_tb;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic [3:0]   in_pic_no;
    logic [1:0]   in_ratio_mode;
    logic         out_valid;
    logic [7:0]   out_data;
    logic [3:0]   awid_s_inf;
    logic [31:0]  awaddr_s_inf;
    logic [2:0]   awsize_s_inf;
    logic [1:0]   awburst_s_inf;
    logic [7:0]   awlen_s_inf;
    logic         awvalid_s_inf;
    logic         awready_s_inf;
    logic [127:0] wdata_s_inf;
    logic         wlast_s_inf;
    logic         wvalid_s_inf;
    logic         wready_s_inf;
    logic         bvalid_s_inf;
    logic         bready_s_inf;
    logic [3:0]   arid_s_inf;
    logic [31:0]  araddr_s_inf;
    logic [7:0]   arlen_s_inf;
    logic [2:0]   arsize_s_inf;
    logic [1:0]   arburst_s_inf;
    logic         arvalid_s_inf;
    logic         arready_s_inf;
    logic [127:0] rdata_s_inf;
    logic         rlast_s_inf;
    logic         rvalid_s_inf;
    logic         rready_s_inf;

    // picture 3 comes back and reads its own write-back
    logic [3:0] pic_table [8]   = '{4'd3, 4'd5, 4'd9, 4'd12, 4'd3, 4'd0, 4'd15, 4'd7};
    logic [1:0] ratio_table [8] = '{2'd1, 2'd0, 2'd3, 2'd2, 2'd3, 2'd1, 2'd0, 2'd3};

    logic [127:0] shadow [16 * isp_pkg::BURST_BEATS];
    int           pulses = 0;
    int           cycles = 0;
    logic         passed = 1'b0;
    logic         fail_shown = 1'b0;

    isp_clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    isp_top isp_top_i (.*);

    isp_dram_model u_dram (.*);

    bind isp_top isp_chk u_chk (.*);

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic logic [7:0] scale_pixel(input logic [7:0] p, input logic [1:0] r);
        int v;
        case (r)
            2'd0:    v = p / 4;
            2'd1:    v = p / 2;
            2'd2:    v = p;
            default: v = (2 * p > 255) ? 255 : 2 * p;
        endcase
        return 8'(v);
    endfunction

    function automatic isp_pkg::pixel_beat_t scale_beat(input isp_pkg::pixel_beat_t b,
                                                        input logic [1:0] r);
        isp_pkg::pixel_beat_t s;
        for (int i = 0; i < isp_pkg::PIXELS_PER_BEAT; i++) begin
            s.pix[i] = scale_pixel(b.pix[i], r);
        end
        return s;
    endfunction

    // red and blue weigh a quarter, green a half
    function automatic int beat_grey(input isp_pkg::pixel_beat_t b, input int channel);
        int sum;
        sum = 0;
        for (int i = 0; i < isp_pkg::PIXELS_PER_BEAT; i++) begin
            sum += (channel == 1) ? b.pix[i] / 2 : b.pix[i] / 4;
        end
        return sum;
    endfunction

    // ==================================================================
    // checks
    // ==================================================================
    task automatic stop_with_failure();
        fail_shown = 1'b1;
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_beat(input isp_pkg::pixel_beat_t got, input isp_pkg::pixel_beat_t exp,
                              input int idx);
        if (got !== exp) begin
            $display("Error at %0t ns: memory beat %0d is %h, expected %h",
                     $time, idx, got.word, exp.word);
            stop_with_failure();
        end
    endtask

    task automatic run_request(input int n);
        int                   base;
        int                   grey;
        logic [7:0]           exp_luma;
        isp_pkg::pixel_beat_t old_beat;
        isp_pkg::pixel_beat_t new_beat;

        base = int'(pic_table[n]) * isp_pkg::BURST_BEATS;
        grey = 0;
        for (int k = 0; k < isp_pkg::BURST_BEATS; k++) begin
            old_beat.word = u_dram.mem[base + k];
            new_beat = scale_beat(old_beat, ratio_table[n]);
            grey += beat_grey(new_beat, k / isp_pkg::BEATS_PER_CHANNEL);
            shadow[base + k] = new_beat.word;
        end
        exp_luma = 8'(grey >> isp_pkg::LUMA_SHIFT);

        @(posedge clk);
        if (pulses != n) begin
            $display("out_valid pulsed %0d times before request %0d", pulses, n);
            stop_with_failure();
        end
        in_valid      <= 1'b1;
        in_pic_no     <= pic_table[n];
        in_ratio_mode <= ratio_table[n];
        @(posedge clk);
        in_valid <= 1'b0;

        do begin
            @(negedge clk);
        end while (out_valid !== 1'b1);
        check_byte(out_data, exp_luma, "out_data");

        // whole memory, so untouched pictures are covered too
        for (int i = 0; i < 16 * isp_pkg::BURST_BEATS; i++) begin
            check_beat(u_dram.mem[i], shadow[i], i);
        end
    endtask

    // ==================================================================
    // stimulus
    // ==================================================================
    initial begin
        in_valid      <= 1'b0;
        in_pic_no     <= '0;
        in_ratio_mode <= '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i < 16 * isp_pkg::BURST_BEATS; i++) begin
            shadow[i] = u_dram.mem[i];
        end
        for (int n = 0; n < $size(pic_table); n++) begin
            run_request(n);
        end
        repeat (20) @(negedge clk);
        if (pulses == $size(pic_table)) begin
            passed = 1'b1;
            $display("All tests passed");
            $finish;
        end else begin
            $display("out_valid pulsed %0d times for %0d requests", pulses, $size(pic_table));
            stop_with_failure();
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                pulses++;
            end else begin
                check_byte(out_data, 8'd0, "idle out_data");
            end
        end
    end

    // each request gets 600 cycles
    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > $size(pic_table) * 600) begin
                $display("Timeout: no final result after %0d cycles", cycles);
                stop_with_failure();
            end
        end
    end

    // a failed assertion ends the run outside the paths above
    final begin
        if (!passed && !fail_shown) begin
            $display("Some tests failed");
        end
    end

endmodule
